// File: files.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_lookup.sv
verilog/icache_refill.sv
verilog/icache_top.sv
tb/icache_props.sv
tb/icache_tb.sv

// File: include/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// msb of a cpu byte address
`define MSB_POS__ICACHE_CPU_ADDR 31

// field msb positions within the cpu address struct
// tag sits above the line index
`define MSB_POS__ICACHE_ADDR__TAG 22

// picks one of 16 lines
`define MSB_POS__ICACHE_ADDR__LINE_INDEX 3

// word within the line, 8 words
`define MSB_POS__ICACHE_ADDR__LOW_BASE_ADDR 2

`endif

// File: tb/icache_props.sv
module icache_props
(
	input logic clk,
	input logic arst_n,
	input icache_pkg::icache_refill_state_t state,
	input logic miss,
	input icache_pkg::icache_mem_out_t mem_out,
	input logic valid
);
	timeunit 1ns;
	timeprecision 1ps;
	import icache_pkg::*;

	// failed assertions in this instance
	int unsigned fail_count = 0;

	// line request is a single pulse
	req_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		mem_out.req |=> !mem_out.req)
	else
	begin
		$error("mem_out.req held high for more than one cycle");
		fail_count++;
	end

	// one refill outstanding at a time
	// a new miss must find the refill stage idle
	miss_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		miss |-> (state == st_idle))
	else
	begin
		$error("miss pulse arrived while a refill was still running");
		fail_count++;
	end

	// whole lines only
	req_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		mem_out.req |-> (mem_out.addr[LINE_OFFSET_WIDTH-1:0] == '0))
	else
	begin
		$error("mem_out.addr not line aligned");
		fail_count++;
	end

	// no answer while reset holds
	valid_in_reset: assert property (@(posedge clk) !arst_n |-> !valid)
	else
	begin
		$error("req_out.valid high during reset");
		fail_count++;
	end

endmodule

// refill stage has no cpu answer
bind icache_refill icache_props refill_props
(
	.clk(clk),
	.arst_n(arst_n),
	.state(state_q),
	.miss(miss),
	.mem_out(mem_out),
	.valid(1'b0)
);

// lookup stage has no memory port or refill state
bind icache_lookup icache_props lookup_props
(
	.clk(clk),
	.arst_n(arst_n),
	.state(icache_pkg::st_idle),
	.miss(1'b0),
	.mem_out('0),
	.valid(valid_q)
);

// File: tb/icache_tb.sv
module icache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import icache_pkg::*;

	localparam int unsigned SEED = 32'hf81c_da17;
	localparam int NUM_DELAYS = 512;

	// one cpu request waiting for its answer
	typedef struct packed {
		icache_addr_t addr;
		logic hit;
		logic [31:0] issue_cycle;
	} pending_t;

	logic clk = 1'b0;
	logic arst_n;
	icache_req_in_t req_in;
	icache_mem_in_t mem_in = '0;
	icache_req_out_t req_out;
	icache_mem_out_t mem_out;

	// shadow tag and valid state
	logic shadow_valid [NUM_LINES];
	icache_tag_t shadow_tag [NUM_LINES];

	pending_t pending [$];
	logic [31:0] seen_instr [$];
	int unsigned mem_delays [NUM_DELAYS];
	int unsigned cycle = 0;
	int unsigned issued = 0;
	int unsigned miss_count = 0;
	int unsigned mem_req_count = 0;
	int unsigned mem_served = 0;
	int unsigned delay;

	// compare process state
	logic front_fetched = 1'b0;
	pending_t front;
	logic [31:0] line_addr;
	icache_mem_out_t exp_mem;
	icache_req_out_t exp_out;
	logic [31:0] line_addr_mem;

	icache_top uut
	(
		.clk(clk),
		.arst_n(arst_n),
		.req_in(req_in),
		.mem_in(mem_in),
		.req_out(req_out),
		.mem_out(mem_out)
	);

	always #10 clk = ~clk;

	// per-word pattern, odd multiplier keeps words apart
	function automatic logic [31:0] word_hash(input logic [31:0] word_addr);
		return (word_addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
	endfunction

	// expected instruction, bits 1..0 dropped
	function automatic logic [31:0] expected_instr(input logic [31:0] addr);
		return word_hash({addr[31:2], 2'b00});
	endfunction

	// full line as memory holds it
	function automatic icache_line_t memory_line(input logic [31:0] base);
		icache_line_t line;
		for (int w = 0; w < LINE_WORDS; w++)
			line[w] = word_hash(base + 32'(4 * w));
		return line;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_instr(input icache_req_out_t got, input icache_req_out_t exp);
		if (got.valid !== exp.valid)
			fail_run($sformatf("mismatch at %0t: req_out.valid got %0b expected %0b",
				$time, got.valid, exp.valid));
		if (got.instr !== exp.instr)
			fail_run($sformatf("mismatch at %0t: req_out.instr got %h expected %h",
				$time, got.instr, exp.instr));
	endtask

	task automatic check_mem_req(input icache_mem_out_t got, input icache_mem_out_t exp);
		if (got.req !== exp.req)
			fail_run($sformatf("mismatch at %0t: mem_out.req got %0b expected %0b",
				$time, got.req, exp.req));
		if (got.addr !== exp.addr)
			fail_run($sformatf("mismatch at %0t: mem_out.addr got %h expected %h",
				$time, got.addr, exp.addr));
	endtask

	task automatic check_hit_timing(input int unsigned got_cycle, input int unsigned exp_cycle);
		if (got_cycle != exp_cycle)
			fail_run($sformatf("mismatch at %0t: req_out.valid cycle got %0d expected %0d",
				$time, got_cycle, exp_cycle));
	endtask

	task automatic check_miss_timing(input int unsigned got_cycle, input int unsigned exp_cycle);
		if (got_cycle != exp_cycle)
			fail_run($sformatf("mismatch at %0t: mem_out.req cycle got %0d expected %0d",
				$time, got_cycle, exp_cycle));
	endtask

	// last line's words must all differ
	task automatic check_distinct();
		if (seen_instr.size() != LINE_WORDS)
			fail_run($sformatf("word select returned %0d words instead of %0d",
				seen_instr.size(), LINE_WORDS));
		for (int i = 0; i < LINE_WORDS; i++)
			for (int j = i + 1; j < LINE_WORDS; j++)
				if (seen_instr[i] == seen_instr[j])
					fail_run("two words of one line came back equal");
	endtask

	// strobe one request, return in the cycle its valid is high
	task automatic send_req(input logic [31:0] addr);
		icache_addr_t a;
		pending_t p;
		a = addr;
		p.addr = a;
		p.hit = shadow_valid[a.line_index] && (shadow_tag[a.line_index] == a.tag);
		p.issue_cycle = cycle;
		if (!p.hit)
		begin
			shadow_valid[a.line_index] = 1'b1;
			shadow_tag[a.line_index] = a.tag;
			miss_count++;
		end
		pending.push_back(p);
		issued++;
		req_in.req = 1'b1;
		req_in.addr = a;
		@(posedge clk);
		#2;
		req_in.req = 1'b0;
		while (!req_out.valid)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	// let the compare process catch up, realign to drive time
	task automatic settle();
		@(negedge clk);
		#1;
		@(posedge clk);
		#2;
	endtask

	// cycle count and watchdog
	always @(posedge clk)
	begin
		cycle = cycle + 1;
		if (cycle > 40 * issued + 200)
			fail_run($sformatf("timeout after %0d cycles with %0d requests issued",
				cycle, issued));
	end

	// memory, answers each line request after a drawn delay
	always @(negedge clk)
	begin
		if (arst_n && mem_out.req)
		begin
			line_addr_mem = mem_out.addr;
			delay = mem_delays[mem_served % NUM_DELAYS];
			mem_served++;
			repeat (delay) @(posedge clk);
			#2;
			mem_in.valid = 1'b1;
			mem_in.data = memory_line(line_addr_mem);
			@(posedge clk);
			#2;
			mem_in.valid = 1'b0;
			mem_in.data = '0;
		end
	end

	// compare, outputs sampled mid cycle
	always @(negedge clk)
	begin
		if (arst_n)
		begin
			if (mem_out.req)
			begin
				if (pending.size() == 0)
					fail_run("line request with no cpu request outstanding");
				front = pending[0];
				if (front.hit)
					fail_run("line request raised for a predicted hit");
				if (front_fetched)
					fail_run("second line request for a single miss");
				line_addr = front.addr & ~32'h1f;
				exp_mem.req = 1'b1;
				exp_mem.addr = line_addr;
				check_mem_req(mem_out, exp_mem);
				// miss pulse, then st_request
				check_miss_timing(cycle, front.issue_cycle + 2);
				front_fetched = 1'b1;
				mem_req_count++;
			end
			if (req_out.valid)
			begin
				if (pending.size() == 0)
					fail_run("instruction returned with no cpu request outstanding");
				front = pending.pop_front();
				exp_out.valid = 1'b1;
				exp_out.instr = expected_instr(front.addr);
				check_instr(req_out, exp_out);
				if (front.hit)
					check_hit_timing(cycle, front.issue_cycle + 1);
				else if (!front_fetched)
					fail_run("miss answered without a line request");
				front_fetched = 1'b0;
				seen_instr.push_back(req_out.instr);
			end
		end
	end

	initial
	begin
		arst_n = 1'b1;
		req_in = '0;
		void'($urandom(SEED));
		for (int i = 0; i < NUM_DELAYS; i++)
			mem_delays[i] = $urandom_range(6, 1);
		for (int i = 0; i < NUM_LINES; i++)
		begin
			shadow_valid[i] = 1'b0;
			shadow_tag[i] = '0;
		end
		#1;
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;
		@(posedge clk);
		#2;
		// cold misses, word 0 of every line
		for (int i = 0; i < NUM_LINES; i++)
			send_req(32'h0000_1000 + 32'(i * 32));
		// same lines, now resident
		for (int i = 0; i < NUM_LINES; i++)
			send_req(32'h0000_1000 + 32'(i * 32) + 32'd28);
		// back to back over lines 0..7
		for (int i = 0; i < 64; i++)
			send_req(32'h0000_1000 + 32'(i * 4));
		// line 3, every word, junk in bits 1..0
		settle();
		seen_instr.delete();
		for (int w = 0; w < LINE_WORDS; w++)
			send_req(32'h0000_1060 + 32'(w * 4) + 32'($urandom_range(3, 0)));
		settle();
		check_distinct();
		// index 5 with two tags, each access evicts the other
		for (int i = 0; i < 12; i++)
			send_req((i % 2 == 0) ? 32'h0000_40a4 : 32'h0000_80a8);
		// 32 lines of window over 16 slots
		for (int i = 0; i < 300; i++)
			send_req(32'h0000_2000 + ($urandom() % 32'h400));
		settle();
		if (pending.size() != 0)
			fail_run($sformatf("%0d requests never answered", pending.size()));
		if (mem_req_count != miss_count)
			fail_run($sformatf("mismatch at %0t: mem_out.req count got %0d expected %0d",
				$time, mem_req_count, miss_count));
		if (uut.lookup.lookup_props.fail_count + uut.refill.refill_props.fail_count == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			fail_run("bound assertions on the lookup or refill stage failed");
	end

endmodule

// File: verilog/icache_lookup.sv
module icache_lookup
(
	input logic clk,
	input logic arst_n,
	input icache_pkg::icache_req_in_t req_in,
	input icache_pkg::icache_req_in_t replay,
	input icache_pkg::icache_fill_t fill,
	output icache_pkg::icache_req_out_t req_out,
	output logic miss,
	output icache_pkg::icache_addr_t miss_addr
);
	import icache_pkg::*;

	// storage, one entry per line
	icache_line_t lines_arr [NUM_LINES];
	icache_tag_t tags_arr [NUM_LINES];
	logic [NUM_LINES-1:0] valid_flags;

	// request actually looked up this cycle
	icache_req_in_t lookup_req;
	icache_addr_t lookup_addr;

	logic index_valid;
	logic tag_match;
	logic hit;
	logic lookup_miss;
	logic [INSTR_WIDTH-1:0] hit_word;

	// output side registers
	logic valid_q;
	logic [INSTR_WIDTH-1:0] instr_q;
	logic miss_q;
	icache_addr_t miss_addr_q;

	// replay wins the mux
	// cpu is held off by the spacing rule while a refill runs
	always_comb
	begin
		if (replay.req)
			lookup_req = replay;
		else
			lookup_req = req_in;
	end

	assign lookup_addr = lookup_req.addr;

	// tag compare only matters when the line is filled
	assign index_valid = valid_flags[lookup_addr.line_index];
	assign tag_match = (tags_arr[lookup_addr.line_index] == lookup_addr.tag);

	assign hit = lookup_req.req && index_valid && tag_match;
	assign lookup_miss = lookup_req.req && !hit;

	// word select, byte offset ignored
	assign hit_word = lines_arr[lookup_addr.line_index][lookup_addr.low_base_addr];

	// fill port, whole line plus tag in one edge
	always_ff @(posedge clk)
	begin
		if (fill.we)
		begin
			lines_arr[fill.line_index] <= fill.data;
			tags_arr[fill.line_index] <= fill.tag;
		end
	end

	// valid flags
	// nothing clears them besides reset
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			valid_flags <= '0;
		else if (fill.we)
			valid_flags[fill.line_index] <= 1'b1;
	end

	// result pulses, one cycle each
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_q <= 1'b0;
			miss_q <= 1'b0;
		end
		else
		begin
			valid_q <= hit;
			miss_q <= lookup_miss;
		end
	end

	// data side
	// held until the next hit or miss
	always_ff @(posedge clk)
	begin
		if (hit)
			instr_q <= hit_word;
		if (lookup_miss)
			miss_addr_q <= lookup_addr;
	end

	// to the cpu
	assign req_out.valid = valid_q;
	assign req_out.instr = instr_q;

	// to refill
	assign miss = miss_q;
	assign miss_addr = miss_addr_q;

endmodule

// File: verilog/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

	// address geometry, derived from the header macros
	localparam int CPU_ADDR_WIDTH = `MSB_POS__ICACHE_CPU_ADDR + 1;
	localparam int TAG_WIDTH = `MSB_POS__ICACHE_ADDR__TAG + 1;
	localparam int LINE_INDEX_WIDTH = `MSB_POS__ICACHE_ADDR__LINE_INDEX + 1;
	localparam int WORD_SEL_WIDTH = `MSB_POS__ICACHE_ADDR__LOW_BASE_ADDR + 1;

	// one instruction word
	localparam int INSTR_WIDTH = 32;

	// line and array sizes
	localparam int LINE_WORDS = 1 << WORD_SEL_WIDTH;
	localparam int LINE_WIDTH = LINE_WORDS * INSTR_WIDTH;
	localparam int NUM_LINES = 1 << LINE_INDEX_WIDTH;

	// byte offset of a line, 5 bits for 32 bytes
	localparam int LINE_OFFSET_WIDTH = $clog2(LINE_WIDTH / 8);
	// leftover bits below the word select
	localparam int BYTE_OFFSET_WIDTH = LINE_OFFSET_WIDTH - WORD_SEL_WIDTH;

	typedef logic [TAG_WIDTH-1:0] icache_tag_t;

	// word 0 in the low 32 bits
	typedef logic [LINE_WORDS-1:0][INSTR_WIDTH-1:0] icache_line_t;

	// cpu byte address split into its cache fields
	typedef struct packed {
		icache_tag_t tag;
		logic [LINE_INDEX_WIDTH-1:0] line_index;
		logic [WORD_SEL_WIDTH-1:0] low_base_addr;
		logic [BYTE_OFFSET_WIDTH-1:0] byte_offset;
	} icache_addr_t;

	// cpu read request, strobe plus address
	typedef struct packed {
		logic req;
		icache_addr_t addr;
	} icache_req_in_t;

	// answer back to the cpu
	typedef struct packed {
		logic valid;
		logic [INSTR_WIDTH-1:0] instr;
	} icache_req_out_t;

	// line request toward memory
	typedef struct packed {
		logic req;
		logic [CPU_ADDR_WIDTH-1:0] addr;
	} icache_mem_out_t;

	// line returned by memory
	typedef struct packed {
		logic valid;
		icache_line_t data;
	} icache_mem_in_t;

	// array write port from refill into lookup
	typedef struct packed {
		logic we;
		logic [LINE_INDEX_WIDTH-1:0] line_index;
		icache_tag_t tag;
		icache_line_t data;
	} icache_fill_t;

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_wait,
		st_replay
	} icache_refill_state_t;

endpackage

// File: verilog/icache_refill.sv
module icache_refill
(
	input logic clk,
	input logic arst_n,
	input logic miss,
	input icache_pkg::icache_addr_t miss_addr,
	input icache_pkg::icache_mem_in_t mem_in,
	output icache_pkg::icache_mem_out_t mem_out,
	output icache_pkg::icache_fill_t fill,
	output icache_pkg::icache_req_in_t replay
);
	import icache_pkg::*;

	icache_refill_state_t state_q;
	icache_refill_state_t state_d;

	// address of the outstanding miss
	icache_addr_t addr_q;
	// returned line, held for the fill write
	icache_line_t data_q;

	logic fill_we_q;
	logic replay_req_q;

	logic miss_accept;
	logic line_accept;

	// miss taken only when idle
	assign miss_accept = (state_q == st_idle) && miss;
	// memory valid only counts while waiting
	assign line_accept = (state_q == st_wait) && mem_in.valid;

	// next state
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			st_idle:
			begin
				if (miss)
					state_d = st_request;
			end
			st_request:
				state_d = st_wait;
			st_wait:
			begin
				// memory may take any number of cycles
				if (mem_in.valid)
					state_d = st_replay;
			end
			st_replay:
				state_d = st_idle;
			default:
				state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q <= st_idle;
			fill_we_q <= 1'b0;
			replay_req_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			// write lands one edge after memory valid
			fill_we_q <= line_accept;
			// replay one cycle later, after the arrays are written
			replay_req_q <= (state_q == st_replay);
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss_accept)
			addr_q <= miss_addr;
		if (line_accept)
			data_q <= mem_in.data;
	end

	// single-cycle line request while in st_request
	assign mem_out.req = (state_q == st_request);
	// line aligned, word and byte bits zeroed
	assign mem_out.addr = {addr_q.tag, addr_q.line_index, {LINE_OFFSET_WIDTH{1'b0}}};

	// index and tag straight from the held address
	assign fill.we = fill_we_q;
	assign fill.line_index = addr_q.line_index;
	assign fill.tag = addr_q.tag;
	assign fill.data = data_q;

	// original address again, lookup answers it as a hit
	assign replay.req = replay_req_q;
	assign replay.addr = addr_q;

endmodule

// File: verilog/icache_top.sv
module icache_top
(
	input logic clk,
	input logic arst_n,
	input icache_pkg::icache_req_in_t req_in,
	input icache_pkg::icache_mem_in_t mem_in,
	output icache_pkg::icache_req_out_t req_out,
	output icache_pkg::icache_mem_out_t mem_out
);
	import icache_pkg::*;

	// lookup to refill
	logic miss;
	icache_addr_t miss_addr;

	// refill back to lookup
	icache_fill_t fill;
	icache_req_in_t replay;

	// arrays, hit path and cpu-facing output
	icache_lookup lookup
	(
		.clk(clk),
		.arst_n(arst_n),
		.req_in(req_in),
		.replay(replay),
		.fill(fill),
		.req_out(req_out),
		.miss(miss),
		.miss_addr(miss_addr)
	);

	// miss handling toward memory
	icache_refill refill
	(
		.clk(clk),
		.arst_n(arst_n),
		.miss(miss),
		.miss_addr(miss_addr),
		.mem_in(mem_in),
		.mem_out(mem_out),
		.fill(fill),
		.replay(replay)
	);

endmodule
